//--- tb.f
+incdir+include
source/mcu_pkg.sv
source/emul_cfg_decode.sv
source/store_seq.sv
source/wr_stream_pipe.sv
source/mcu_store_top.sv
tb/mcu_store_chk.sv
tb/tb_mcu_store.sv

//--- Bender.yml
package:
  name: mcu_store

export_include_dirs:
  - include

sources:
  - source/mcu_pkg.sv
  - source/emul_cfg_decode.sv
  - source/store_seq.sv
  - source/wr_stream_pipe.sv
  - source/mcu_store_top.sv
  - target: test
    files:
      - tb/mcu_store_chk.sv
      - tb/tb_mcu_store.sv

//--- tb/tb_mcu_store.sv
/*
 * Testbench for mcu_store_top with LCG stimulus,
 * store buffer and write channel models and a reference model
 */
`timescale 1ns/1ps
`include "mcu_cfg.svh"

module tb_mcu_store;

  localparam int NUM_STORES = 40;
  localparam int MAX_CYCLES = NUM_STORES * 200;

  logic           clk;
  logic           rstn;
  logic           mcu_st_vld_i;
  logic           mcu_st_rdy_o;
  mcu_pkg::sew_t  mcu_sew_i;
  mcu_pkg::lmul_t mcu_lmul_i;
  mcu_pkg::sew_t  mcu_data_width_i;
  logic           mcu_unit_ld_st_i;
  logic           mcu_strided_ld_st_i;
  mcu_pkg::sew_t  cfg_store_data_sew_o;
  mcu_pkg::lmul_t cfg_store_data_lmul_o;
  logic           store_cntr_rst_o;
  logic           store_baseaddr_set_o;
  logic           store_baseaddr_update_o;
  logic           sbuff_wen_o;
  logic           sbuff_ren_o;
  logic           sbuff_read_stall_o;
  logic           sbuff_write_done_i;
  logic           sbuff_read_done_i;
  logic           vlane_store_valid_i;
  logic           ctrl_wstart_o;
  logic           ctrl_wdone_i;
  logic           wr_tvalid_o;
  logic           wr_tready_i;

  logic [31:0] lcg_state;
  int          cycles;
  // Current store and its model counters
  bit          cur_unit;
  int          n_elem;
  int          wr_cnt;
  int          rd_cnt;
  int          beat_cnt;
  int          wen_seen;
  int          wstart_seen;
  int          upd_seen;
  int          set_seen;
  int          wdone_seen;
  logic        rdy_seen;

  mcu_store_top dut (.*);

  bind mcu_store_top mcu_store_chk u_chk (
    .clk           (clk),
    .rstn          (rstn),
    .mcu_st_rdy_i  (mcu_st_rdy_o),
    .sbuff_wen_i   (sbuff_wen_o),
    .ctrl_wstart_i (ctrl_wstart_o),
    .wr_tvalid_i   (wr_tvalid_o),
    .wr_tready_i   (wr_tready_i)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic int unsigned next_rand(int unsigned range);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:8] % range;
  endfunction

  task automatic check_value(string name, int actual, int expected);
    if (actual != expected) begin
      $display("** Error at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  ////////////////////////////////////////
  // One clock cycle of all models
  ////////////////////////////////////////

  task automatic step();
    logic wen;
    logic ren;
    logic cntr_rst;
    logic beat;
    // Outputs are stable mid-cycle
    @(negedge clk);
    wen      = sbuff_wen_o;
    ren      = sbuff_ren_o;
    cntr_rst = store_cntr_rst_o;
    beat     = wr_tvalid_o && wr_tready_i;
    rdy_seen = mcu_st_rdy_o;
    check_value("wr_tvalid_o while wr_tready_i low", wr_tvalid_o && !wr_tready_i, 0);
    check_value("bound assertion failures", dut.u_chk.assert_fails, 0);
    wen_seen    += wen;
    wstart_seen += ctrl_wstart_o;
    upd_seen    += store_baseaddr_update_o;
    set_seen    += store_baseaddr_set_o;
    wdone_seen  += ctrl_wdone_i;
    beat_cnt    += beat;
    @(posedge clk);
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout after %0d cycles, a store did not complete", cycles);
      $display("Simulation FAILED");
      $fatal(1, "cycle limit reached");
    end
    #2;
    // Store buffer model with done levels held until the counters clear
    if (cntr_rst) begin
      wr_cnt             = 0;
      rd_cnt             = 0;
      sbuff_write_done_i = 1'b0;
      sbuff_read_done_i  = 1'b0;
    end else begin
      wr_cnt += wen;
      rd_cnt += ren;
      if (wen && wr_cnt == n_elem) sbuff_write_done_i = 1'b1;
      if (ren && rd_cnt == n_elem) sbuff_read_done_i = 1'b1;
    end
    // Write channel model with a done pulse after the burst or each strided beat
    ctrl_wdone_i        = beat && (!cur_unit || beat_cnt == n_elem);
    vlane_store_valid_i = next_rand(4) != 0;
    wr_tready_i         = next_rand(4) != 0;
  endtask

  ////////////////////////////////////////
  // One random store and its checks
  ////////////////////////////////////////

  task automatic run_store();
    int sew;
    int width;
    int diff;
    int lo;
    int hi;
    int lmul;
    cur_unit = next_rand(2) == 0;
    sew      = next_rand(`MCU_SEW_MAX + 1);
    width    = next_rand(`MCU_SEW_MAX + 1);
    diff     = width - sew;
    // Keep both LMUL and EMUL inside -3..3
    lo       = (diff < 0) ? -3 - diff : -3;
    hi       = (diff > 0) ? 3 - diff : 3;
    lmul     = lo + next_rand(hi - lo + 1);
    n_elem   = 1 + next_rand(8);
    while (!rdy_seen) step();
    wen_seen    = 0;
    wstart_seen = 0;
    upd_seen    = 0;
    set_seen    = 0;
    wdone_seen  = 0;
    beat_cnt    = 0;
    mcu_st_vld_i        = 1'b1;
    mcu_sew_i           = sew[2:0];
    mcu_lmul_i          = lmul[2:0];
    mcu_data_width_i    = width[2:0];
    mcu_unit_ld_st_i    = cur_unit;
    mcu_strided_ld_st_i = !cur_unit;
    step();
    mcu_st_vld_i = 1'b0;
    step();
    step();
    check_value("cfg_store_data_sew_o", cfg_store_data_sew_o, width);
    check_value("cfg_store_data_lmul_o", cfg_store_data_lmul_o, (lmul + diff) & 7);
    while (!rdy_seen) step();
    check_value("sbuff_wen_o cycles", wen_seen, n_elem);
    check_value("sbuff_ren_o cycles", rd_cnt, n_elem);
    check_value("write beats", beat_cnt, n_elem);
    check_value("store_baseaddr_set_o pulses", set_seen, 1);
    check_value("ctrl_wstart_o pulses", wstart_seen, cur_unit ? 1 : n_elem);
    check_value("store_baseaddr_update_o pulses", upd_seen, cur_unit ? 0 : wdone_seen);
  endtask

  initial begin
    lcg_state           = 32'h2c6cb41e;
    cycles              = 0;
    cur_unit            = 1'b0;
    n_elem              = 1;
    wr_cnt              = 0;
    rd_cnt              = 0;
    beat_cnt            = 0;
    rdy_seen            = 1'b0;
    rstn                = 1'b0;
    mcu_st_vld_i        = 1'b0;
    mcu_sew_i           = '0;
    mcu_lmul_i          = '0;
    mcu_data_width_i    = '0;
    mcu_unit_ld_st_i    = 1'b0;
    mcu_strided_ld_st_i = 1'b0;
    sbuff_write_done_i  = 1'b0;
    sbuff_read_done_i   = 1'b0;
    vlane_store_valid_i = 1'b0;
    ctrl_wdone_i        = 1'b0;
    wr_tready_i         = 1'b0;
    repeat (4) @(posedge clk);
    #2 rstn = 1'b1;
    // Idle levels out of reset
    @(negedge clk);
    check_value("mcu_st_rdy_o", mcu_st_rdy_o, 1);
    check_value("store_cntr_rst_o", store_cntr_rst_o, 0);
    check_value("store_baseaddr_set_o", store_baseaddr_set_o, 0);
    check_value("store_baseaddr_update_o", store_baseaddr_update_o, 0);
    check_value("sbuff_wen_o", sbuff_wen_o, 0);
    check_value("sbuff_ren_o", sbuff_ren_o, 0);
    check_value("sbuff_read_stall_o", sbuff_read_stall_o, 0);
    check_value("ctrl_wstart_o", ctrl_wstart_o, 0);
    check_value("wr_tvalid_o", wr_tvalid_o, 0);
    step();
    for (int i = 0; i < NUM_STORES; i++) begin
      run_store();
    end
    if (dut.u_chk.assert_fails == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Simulation FAILED");
      $fatal(1, "bound assertions failed");
    end
  end

endmodule

//--- tb/mcu_store_chk.sv
/*
 * Concurrent assertions on the store MCU handshake and write channel
 */
`timescale 1ns/1ps

module mcu_store_chk (
  input  logic clk,
  input  logic rstn,
  input  logic mcu_st_rdy_i,
  input  logic sbuff_wen_i,
  input  logic ctrl_wstart_i,
  input  logic wr_tvalid_i,
  input  logic wr_tready_i
);

  // Number of failed assertions
  int assert_fails = 0;

  // Buffer is only filled during a store
  rdy_wen_excl: assert property (@(posedge clk) disable iff (!rstn)
    !(mcu_st_rdy_i && sbuff_wen_i))
    else begin
      $error("sbuff_wen_o high while mcu_st_rdy_o is high");
      assert_fails++;
    end

  // Write start only while busy
  wstart_busy: assert property (@(posedge clk) disable iff (!rstn)
    ctrl_wstart_i |-> !mcu_st_rdy_i)
    else begin
      $error("ctrl_wstart_o while mcu_st_rdy_o is high");
      assert_fails++;
    end

  // Valid is masked under back-pressure
  valid_masked: assert property (@(posedge clk) disable iff (!rstn)
    wr_tvalid_i |-> wr_tready_i)
    else begin
      $error("wr_tvalid_o high while wr_tready_i is low");
      assert_fails++;
    end

  ////////////////////////////////////////
  // Start is a single-cycle strobe
  ////////////////////////////////////////

  wstart_pulse: assert property (@(posedge clk) disable iff (!rstn)
    ctrl_wstart_i |=> !ctrl_wstart_i)
    else begin
      $error("ctrl_wstart_o held for more than one cycle");
      assert_fails++;
    end

endmodule

//--- source/mcu_store_top.sv
/*
 * Store side of the vector memory control unit
 * Request decode, store FSM and write-valid line
 */
`timescale 1ns/1ps

module mcu_store_top (
  input  logic           clk,
  input  logic           rstn,
  // Scheduler
  input  logic           mcu_st_vld_i,
  output logic           mcu_st_rdy_o,
  input  mcu_pkg::sew_t  mcu_sew_i,
  input  mcu_pkg::lmul_t mcu_lmul_i,
  input  mcu_pkg::sew_t  mcu_data_width_i,
  input  logic           mcu_unit_ld_st_i,
  input  logic           mcu_strided_ld_st_i,
  // Buffer array configuration
  output mcu_pkg::sew_t  cfg_store_data_sew_o,
  output mcu_pkg::lmul_t cfg_store_data_lmul_o,
  // Buffer array control
  output logic           store_cntr_rst_o,
  output logic           store_baseaddr_set_o,
  output logic           store_baseaddr_update_o,
  output logic           sbuff_wen_o,
  output logic           sbuff_ren_o,
  output logic           sbuff_read_stall_o,
  input  logic           sbuff_write_done_i,
  input  logic           sbuff_read_done_i,
  // Vector lane
  input  logic           vlane_store_valid_i,
  // Write channel
  output logic           ctrl_wstart_o,
  input  logic           ctrl_wdone_i,
  output logic           wr_tvalid_o,
  input  logic           wr_tready_i
);

  logic req;
  logic unit;
  logic strided;
  logic save;
  logic issue;
  logic invalidate;
  logic pipe_empty;

  ////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////

  emul_cfg_decode u_decode (
    .clk                   (clk),
    .rstn                  (rstn),
    .mcu_st_vld_i          (mcu_st_vld_i),
    .mcu_sew_i             (mcu_sew_i),
    .mcu_lmul_i            (mcu_lmul_i),
    .mcu_data_width_i      (mcu_data_width_i),
    .mcu_unit_ld_st_i      (mcu_unit_ld_st_i),
    .mcu_strided_ld_st_i   (mcu_strided_ld_st_i),
    .save_i                (save),
    .req_o                 (req),
    .unit_o                (unit),
    .strided_o             (strided),
    .cfg_store_data_sew_o  (cfg_store_data_sew_o),
    .cfg_store_data_lmul_o (cfg_store_data_lmul_o)
  );

  ////////////////////////////////////////
  // Store sequencer
  ////////////////////////////////////////

  store_seq u_seq (
    .clk                     (clk),
    .rstn                    (rstn),
    .req_i                   (req),
    .unit_i                  (unit),
    .strided_i               (strided),
    .vlane_store_valid_i     (vlane_store_valid_i),
    .sbuff_write_done_i      (sbuff_write_done_i),
    .sbuff_read_done_i       (sbuff_read_done_i),
    .ctrl_wdone_i            (ctrl_wdone_i),
    .wr_tready_i             (wr_tready_i),
    .pipe_empty_i            (pipe_empty),
    .mcu_st_rdy_o            (mcu_st_rdy_o),
    .save_o                  (save),
    .store_cntr_rst_o        (store_cntr_rst_o),
    .store_baseaddr_set_o    (store_baseaddr_set_o),
    .store_baseaddr_update_o (store_baseaddr_update_o),
    .sbuff_wen_o             (sbuff_wen_o),
    .sbuff_ren_o             (sbuff_ren_o),
    .sbuff_read_stall_o      (sbuff_read_stall_o),
    .ctrl_wstart_o           (ctrl_wstart_o),
    .issue_o                 (issue),
    .invalidate_o            (invalidate)
  );

  // Buffer read stall also holds the valid line
  wr_stream_pipe u_pipe (
    .clk          (clk),
    .rstn         (rstn),
    .issue_i      (issue),
    .stall_i      (sbuff_read_stall_o),
    .invalidate_i (invalidate),
    .wr_tvalid_o  (wr_tvalid_o),
    .pipe_empty_o (pipe_empty)
  );

endmodule

//--- source/wr_stream_pipe.sv
/*
 * Stallable write-valid delay line matching the buffer read latency
 */
`timescale 1ns/1ps
`include "mcu_cfg.svh"

module wr_stream_pipe (
  input  logic clk,
  input  logic rstn,
  // From the sequencer
  input  logic issue_i,
  input  logic stall_i,
  input  logic invalidate_i,
  // Write channel valid
  output logic wr_tvalid_o,
  // No read in flight
  output logic pipe_empty_o
);

  // One flag per buffer read stage, index 0 is the newest
  logic [`MCU_RD_LAT-1:0] vld_q;

  ////////////////////////////////////////
  // Delay line
  ////////////////////////////////////////

  // Moves in lock step with the store buffer read path,
  // so both hold together while stall is high
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      vld_q <= '0;
    end else if (!stall_i) begin
      vld_q[0] <= issue_i;
      for (int i = 1; i < `MCU_RD_LAT; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  // Head beat is hidden while the sequencer invalidates
  assign wr_tvalid_o = vld_q[`MCU_RD_LAT-1] & ~invalidate_i;

  assign pipe_empty_o = ~|vld_q;

endmodule

//--- source/store_seq.sv
/*
 * Store FSM for unit-stride and strided stores
 * Drives store buffer enables, write channel start and the valid line
 */
`timescale 1ns/1ps

module store_seq (
  input  logic clk,
  input  logic rstn,
  // Decoded request
  input  logic req_i,
  input  logic unit_i,
  input  logic strided_i,
  // Vector lane
  input  logic vlane_store_valid_i,
  // Store buffer status levels
  input  logic sbuff_write_done_i,
  input  logic sbuff_read_done_i,
  // Write channel controller
  input  logic ctrl_wdone_i,
  input  logic wr_tready_i,
  // Valid line status
  input  logic pipe_empty_i,
  // Scheduler handshake
  output logic mcu_st_rdy_o,
  // Configuration capture
  output logic save_o,
  // Store buffer control
  output logic store_cntr_rst_o,
  output logic store_baseaddr_set_o,
  output logic store_baseaddr_update_o,
  output logic sbuff_wen_o,
  output logic sbuff_ren_o,
  output logic sbuff_read_stall_o,
  // Write channel start
  output logic ctrl_wstart_o,
  // Valid line control
  output logic issue_o,
  output logic invalidate_o
);

  mcu_pkg::store_state_t state_q;
  mcu_pkg::store_state_t state_d;

  ////////////////////////////////////////
  // State register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= mcu_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////
  // Next state and control strobes
  ////////////////////////////////////////

  always_comb begin
    state_d                 = state_q;
    mcu_st_rdy_o            = 1'b0;
    save_o                  = 1'b0;
    store_cntr_rst_o        = 1'b0;
    store_baseaddr_set_o    = 1'b0;
    store_baseaddr_update_o = 1'b0;
    sbuff_wen_o             = 1'b0;
    sbuff_ren_o             = 1'b0;
    sbuff_read_stall_o      = 1'b0;
    ctrl_wstart_o           = 1'b0;
    issue_o                 = 1'b0;
    invalidate_o            = 1'b0;

    case (state_q)
      mcu_pkg::ST_IDLE: begin
        mcu_st_rdy_o = 1'b1;
        // Requests without a store kind are dropped here
        if (req_i && (unit_i || strided_i)) begin
          save_o               = 1'b1;
          store_cntr_rst_o     = 1'b1;
          store_baseaddr_set_o = 1'b1;
          if (unit_i) begin
            state_d = mcu_pkg::ST_UNIT_PREP;
          end else begin
            state_d = mcu_pkg::ST_STRD_PREP;
          end
        end
      end

      // Unit-stride: fill, then one burst over the whole buffer
      mcu_pkg::ST_UNIT_PREP: begin
        if (sbuff_write_done_i) begin
          // First read goes out together with the burst start
          ctrl_wstart_o = 1'b1;
          sbuff_ren_o   = 1'b1;
          issue_o       = 1'b1;
          state_d       = mcu_pkg::ST_UNIT_TX;
        end else begin
          sbuff_wen_o = vlane_store_valid_i;
        end
      end

      mcu_pkg::ST_UNIT_TX: begin
        if (wr_tready_i) begin
          sbuff_ren_o = !sbuff_read_done_i;
          issue_o     = !sbuff_read_done_i;
        end else begin
          // Freeze buffer output and valid line, hide the head beat
          sbuff_read_stall_o = 1'b1;
          invalidate_o       = 1'b1;
        end
        if (sbuff_read_done_i && ctrl_wdone_i) begin
          state_d = mcu_pkg::ST_IDLE;
        end
      end

      // Strided: fill, then one single-beat write per element
      mcu_pkg::ST_STRD_PREP: begin
        if (sbuff_write_done_i) begin
          state_d = mcu_pkg::ST_STRD_TX_PREP;
        end else begin
          sbuff_wen_o = vlane_store_valid_i;
        end
      end

      mcu_pkg::ST_STRD_TX_PREP: begin
        sbuff_ren_o   = 1'b1;
        issue_o       = 1'b1;
        ctrl_wstart_o = 1'b1;
        state_d       = mcu_pkg::ST_STRD_TX;
      end

      mcu_pkg::ST_STRD_TX: begin
        // No new reads; the element in flight waits out back-pressure
        sbuff_read_stall_o = !wr_tready_i;
        invalidate_o       = !wr_tready_i;
        if (ctrl_wdone_i) begin
          store_baseaddr_update_o = 1'b1;
          if (sbuff_read_done_i && pipe_empty_i) begin
            state_d = mcu_pkg::ST_IDLE;
          end else begin
            state_d = mcu_pkg::ST_STRD_TX_PREP;
          end
        end
      end

      default: begin
        state_d = mcu_pkg::ST_IDLE;
      end
    endcase
  end

endmodule

//--- source/emul_cfg_decode.sv
/*
 * Store request register, EMUL arithmetic and store configuration capture
 */
`timescale 1ns/1ps
`include "mcu_cfg.svh"

module emul_cfg_decode (
  input  logic               clk,
  input  logic               rstn,
  // Scheduler side
  input  logic               mcu_st_vld_i,
  input  mcu_pkg::sew_t      mcu_sew_i,
  input  mcu_pkg::lmul_t     mcu_lmul_i,
  input  mcu_pkg::sew_t      mcu_data_width_i,
  input  logic               mcu_unit_ld_st_i,
  input  logic               mcu_strided_ld_st_i,
  // Capture strobe from the sequencer
  input  logic               save_i,
  // Towards the sequencer
  output logic               req_o,
  output logic               unit_o,
  output logic               strided_o,
  // Buffer array configuration
  output mcu_pkg::sew_t      cfg_store_data_sew_o,
  output mcu_pkg::lmul_t     cfg_store_data_lmul_o
);

  // Two guard bits keep the sum exact before it is folded back to 3 bits
  logic signed [`MCU_LMUL_W+1:0] emul_log;
  mcu_pkg::lmul_t                emul;

  ////////////////////////////////////////
  // Request strobe and store kind
  ////////////////////////////////////////

  // Kind bits sampled with the strobe, the scheduler holds them anyway
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      req_o     <= 1'b0;
      unit_o    <= 1'b0;
      strided_o <= 1'b0;
    end else begin
      req_o <= mcu_st_vld_i;
      if (mcu_st_vld_i) begin
        unit_o    <= mcu_unit_ld_st_i;
        strided_o <= mcu_strided_ld_st_i;
      end
    end
  end

  ////////////////////////////////////////
  // EMUL = LMUL * EEW / SEW
  ////////////////////////////////////////

  // In log form this is lmul + eew - sew
  // Width and SEW codes are unsigned, LMUL is two's complement
  assign emul_log = $signed(mcu_lmul_i)
                  + $signed({1'b0, mcu_data_width_i})
                  - $signed({1'b0, mcu_sew_i});

  // Legal combinations land in -3..3, so the low bits hold the code
  assign emul = emul_log[`MCU_LMUL_W-1:0];

  ////////////////////////////////////////
  // Configuration registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cfg_store_data_sew_o  <= '0;
      cfg_store_data_lmul_o <= '0;
    end else if (save_i) begin
      // Data is moved at the element width, not at SEW
      cfg_store_data_sew_o  <= mcu_data_width_i;
      cfg_store_data_lmul_o <= emul;
    end
  end

endmodule

//--- source/mcu_pkg.sv
/*
 * Width typedefs and store sequencer state encoding
 */
`include "mcu_cfg.svh"

package mcu_pkg;

  // Element width code
  // 0 = 8 bit, 1 = 16 bit, 2 = 32 bit, 3 = 64 bit
  typedef logic [`MCU_SEW_W-1:0] sew_t;

  // Register group multiplier as signed log2
  // 0..3 -> 1, 2, 4, 8 and 5..7 -> 1/8, 1/4, 1/2, code 4 reserved
  typedef logic [`MCU_LMUL_W-1:0] lmul_t;

  // Store sequencer states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_UNIT_PREP,
    ST_UNIT_TX,
    ST_STRD_PREP,
    ST_STRD_TX_PREP,
    ST_STRD_TX
  } store_state_t;

endpackage

//--- include/mcu_cfg.svh
/*
 * Widths, code limits and store buffer read latency for the store MCU
 */
`ifndef MCU_CFG_SVH
`define MCU_CFG_SVH

// SEW and element-width code width
`define MCU_SEW_W   3
// LMUL and EMUL code width, signed log2
`define MCU_LMUL_W  3
`define MCU_ADDR_W  32

// Highest SEW code in use, 2 selects 32-bit elements
`define MCU_SEW_MAX 2

// Store buffer read latency in cycles
// Also the depth of the write-valid line
`define MCU_RD_LAT  2

`endif
